/* gunsmoke.f */
+incdir+.
src/gunsmoke_pkg.sv
src/gunsmoke_cen.sv
src/gunsmoke_timer.sv
src/gunsmoke_prom_we.sv
src/gunsmoke_colmix.sv
src/gunsmoke_video.sv
testbench/gunsmoke_video_tb.sv

/* gunsmoke_defines.svh */
/*
 * Video timing, clock divider and download map constants for the video core.
 * Include this header in any RTL or testbench file that needs them.
 */

`ifndef GUNSMOKE_DEFINES_SVH
`define GUNSMOKE_DEFINES_SVH

// Horizontal timing in 6 MHz pixels
`define GS_H_TOTAL      384
`define GS_H_ACTIVE     256
`define GS_HS_START     288
`define GS_HS_END       320

// Vertical timing in lines, start inclusive and end exclusive
`define GS_V_TOTAL      262
`define GS_V_START      16
`define GS_V_END        240
`define GS_VS_START     244
`define GS_VS_END       248

// Download image split, palette PROMs start here
`define GS_PROM_ADDR    22'hA_C000
// Red, green and blue only
`define GS_PROM_COUNT   3

`endif

/* run_sim.sh */
#!/bin/sh
# Build the video core testbench with Verilator and run it.
# The exit status is non-zero unless the testbench reports a pass.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f gunsmoke.f --top-module gunsmoke_video_tb \
    -o gunsmoke_sim || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/gunsmoke_sim)
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "=== PASS ===" && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* src/gunsmoke_cen.sv */
/*
 * Clock enable generator, divides the 48 MHz clock into 12, 6, 3 and 1.5 MHz
 * single-cycle enables. Faster enables are always high with slower ones.
 */

`timescale 1ns/1ps

module gunsmoke_cen (
    input  logic clk,
    input  logic reset,
    output logic cen12,
    output logic cen6,
    output logic cen3,
    output logic cen1p5
);

    logic [4:0] cnt;
    logic [4:0] cnt_next;

    assign cnt_next = cnt + 5'd1;

    // Enables are registered from the next count, so each one is high
    // exactly while the counter sits at the matching all-ones pattern
    always_ff @(posedge clk) begin
        if (reset) begin
            cnt    <= 5'd0;
            cen12  <= 1'b0;
            cen6   <= 1'b0;
            cen3   <= 1'b0;
            cen1p5 <= 1'b0;
        end else begin
            cnt    <= cnt_next;
            cen12  <= &cnt_next[1:0];
            cen6   <= &cnt_next[2:0];
            cen3   <= &cnt_next[3:0];
            cen1p5 <= &cnt_next;
        end
    end

endmodule

/* src/gunsmoke_colmix.sv */
/*
 * Colour mixer. Looks up the pixel index in the red, green and blue palette
 * PROMs over two cen6 stages and blanks the colour outside active video.
 */

`timescale 1ns/1ps

`include "gunsmoke_defines.svh"

module gunsmoke_colmix (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    cen6,
    input  gunsmoke_pkg::pix_t      pixel,
    input  logic                    LHBL,
    input  logic                    LVBL,
    // PROM load port
    input  gunsmoke_pkg::pix_t      prog_addr,
    input  gunsmoke_pkg::col_t      prog_din,
    input  gunsmoke_pkg::prom_we_t  prom_we,
    // Pixel output
    output gunsmoke_pkg::col_t      red,
    output gunsmoke_pkg::col_t      green,
    output gunsmoke_pkg::col_t      blue,
    output logic                    LHBL_dly,
    output logic                    LVBL_dly
);

    localparam int PROMS = `GS_PROM_COUNT;

    // Palette PROMs, index 0 red, 1 green, 2 blue
    gunsmoke_pkg::col_t pal [PROMS][256];

    // Stage 1
    gunsmoke_pkg::pix_t pix_s1;
    logic               lhbl_s1;
    logic               lvbl_s1;
    logic               active_s1;

    // Loaded while downloading, one write per strobe
    for (genvar i = 0; i < PROMS; i++) begin : g_prom
        always_ff @(posedge clk) begin
            if (prom_we[i]) begin
                pal[i][prog_addr] <= prog_din;
            end
        end
    end

    // Stage 1 index register
    always_ff @(posedge clk) begin
        if (cen6) begin
            pix_s1 <= pixel;
        end
    end

    // Stage 1 blanking register
    always_ff @(posedge clk) begin
        if (reset) begin
            lhbl_s1 <= 1'b0;
            lvbl_s1 <= 1'b0;
        end else if (cen6) begin
            lhbl_s1 <= LHBL;
            lvbl_s1 <= LVBL;
        end
    end

    assign active_s1 = lhbl_s1 && lvbl_s1;

    // Stage 2 lookup and blanking, flags follow the colour
    always_ff @(posedge clk) begin
        if (reset) begin
            red      <= '0;
            green    <= '0;
            blue     <= '0;
            LHBL_dly <= 1'b0;
            LVBL_dly <= 1'b0;
        end else if (cen6) begin
            LHBL_dly <= lhbl_s1;
            LVBL_dly <= lvbl_s1;
            if (active_s1) begin
                red   <= pal[0][pix_s1];
                green <= pal[1][pix_s1];
                blue  <= pal[2][pix_s1];
            end else begin
                // Black during blanking
                red   <= '0;
                green <= '0;
                blue  <= '0;
            end
        end
    end

endmodule

/* src/gunsmoke_pkg.sv */
/*
 * Shared types of the video core: counts, colour data and download buses.
 * Referenced by scoped name from each module.
 */

package gunsmoke_pkg;

    // Video counters
    typedef logic [8:0] hpos_t;
    typedef logic [8:0] vpos_t;

    // Colour index, doubles as palette PROM address
    typedef logic [7:0] pix_t;
    // One palette component
    typedef logic [3:0] col_t;

    // Byte address on the download stream
    typedef logic [21:0] dl_addr_t;
    // 16-bit word address on the SDRAM side
    typedef logic [21:0] sd_addr_t;

    // One-hot PROM writes: bit 0 red, bit 1 green, bit 2 blue
    typedef logic [2:0] prom_we_t;

endpackage

/* src/gunsmoke_prom_we.sv */
/*
 * Download decoder. Bytes below the PROM region go to SDRAM as masked 16-bit
 * word writes, bytes above it become palette PROM write strobes.
 */

`timescale 1ns/1ps

`include "gunsmoke_defines.svh"

module gunsmoke_prom_we (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    downloading,
    input  gunsmoke_pkg::dl_addr_t  ioctl_addr,
    input  logic [7:0]              ioctl_data,
    input  logic                    ioctl_wr,
    output gunsmoke_pkg::sd_addr_t  prog_addr,
    output logic [7:0]              prog_data,
    output logic [1:0]              prog_mask,
    output logic                    prog_we,
    output gunsmoke_pkg::prom_we_t  prom_we
);

    localparam gunsmoke_pkg::dl_addr_t PROM_ADDR = `GS_PROM_ADDR;
    localparam logic [3:0] PROM_COUNT = 4'(`GS_PROM_COUNT);

    gunsmoke_pkg::dl_addr_t offset;
    logic                   is_prom;
    logic [3:0]             prom_sel;

    assign is_prom  = ioctl_addr >= PROM_ADDR;
    assign offset   = ioctl_addr - PROM_ADDR;
    assign prom_sel = offset[11:8];

    // Write strobes, one clk after the accepted byte
    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
            prom_we <= '0;
        end else begin
            prog_we <= ioctl_wr && downloading && !is_prom;
            prom_we <= '0;
            if (ioctl_wr && downloading && is_prom && prom_sel < PROM_COUNT) begin
                prom_we <= gunsmoke_pkg::prom_we_t'(3'b001 << prom_sel[1:0]);
            end
        end
    end

    // Address, data and byte mask
    always_ff @(posedge clk) begin
        if (ioctl_wr && downloading) begin
            prog_data <= ioctl_data;
            if (is_prom) begin
                prog_addr <= {14'd0, offset[7:0]};
                prog_mask <= 2'b11;
            end else begin
                prog_addr <= ioctl_addr >> 1;
                // Active low, marks the half of the word left alone
                prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            end
        end
    end

endmodule

/* src/gunsmoke_timer.sv */
/*
 * Video timer. Counts pixels and lines on cen6 and produces blanking and sync.
 * All outputs change together on the clk edge where cen6 is high.
 */

`timescale 1ns/1ps

`include "gunsmoke_defines.svh"

module gunsmoke_timer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cen6,
    output gunsmoke_pkg::hpos_t  H,
    output gunsmoke_pkg::vpos_t  V,
    output logic                 LHBL,
    output logic                 LVBL,
    output logic                 HS,
    output logic                 VS
);

    // Window limits at counter width
    localparam gunsmoke_pkg::hpos_t H_LAST =
        gunsmoke_pkg::hpos_t'(`GS_H_TOTAL - 1);
    localparam gunsmoke_pkg::hpos_t H_ACTIVE =
        gunsmoke_pkg::hpos_t'(`GS_H_ACTIVE);
    localparam gunsmoke_pkg::hpos_t HS_START =
        gunsmoke_pkg::hpos_t'(`GS_HS_START);
    localparam gunsmoke_pkg::hpos_t HS_END =
        gunsmoke_pkg::hpos_t'(`GS_HS_END);

    localparam gunsmoke_pkg::vpos_t V_LAST =
        gunsmoke_pkg::vpos_t'(`GS_V_TOTAL - 1);
    localparam gunsmoke_pkg::vpos_t V_START =
        gunsmoke_pkg::vpos_t'(`GS_V_START);
    localparam gunsmoke_pkg::vpos_t V_END =
        gunsmoke_pkg::vpos_t'(`GS_V_END);
    localparam gunsmoke_pkg::vpos_t VS_START =
        gunsmoke_pkg::vpos_t'(`GS_VS_START);
    localparam gunsmoke_pkg::vpos_t VS_END =
        gunsmoke_pkg::vpos_t'(`GS_VS_END);

    gunsmoke_pkg::hpos_t h_next;
    gunsmoke_pkg::vpos_t v_next;

    // Counts for the coming pixel
    always_comb begin
        h_next = H + 9'd1;
        v_next = V;
        if (H == H_LAST) begin
            h_next = '0;
            if (V == V_LAST) begin
                v_next = '0;
            end else begin
                v_next = V + 9'd1;
            end
        end
    end

    // Flags come from the counts being loaded, so they line up with H and V
    always_ff @(posedge clk) begin
        if (reset) begin
            H    <= '0;
            V    <= '0;
            LHBL <= 1'b1;
            LVBL <= 1'b0;
            HS   <= 1'b0;
            VS   <= 1'b0;
        end else if (cen6) begin
            H    <= h_next;
            V    <= v_next;
            LHBL <= h_next < H_ACTIVE;
            LVBL <= (v_next >= V_START) && (v_next < V_END);
            HS   <= (h_next >= HS_START) && (h_next < HS_END);
            VS   <= (v_next >= VS_START) && (v_next < VS_END);
        end
    end

endmodule

/* src/gunsmoke_video.sv */
/*
 * Video and loading core top level. Wires the clock enables, video timer,
 * download decoder and colour mixer together with no added latency.
 */

`timescale 1ns/1ps

module gunsmoke_video (
    input  logic                    clk,
    input  logic                    reset,
    // Pixel index from the tile and object engines
    input  gunsmoke_pkg::pix_t      pixel,
    // Download stream
    input  logic                    downloading,
    input  gunsmoke_pkg::dl_addr_t  ioctl_addr,
    input  logic [7:0]              ioctl_data,
    input  logic                    ioctl_wr,
    // Clock enables
    output logic                    cen12,
    output logic                    cen6,
    output logic                    cen3,
    output logic                    cen1p5,
    // Video timing
    output gunsmoke_pkg::hpos_t     H,
    output gunsmoke_pkg::vpos_t     V,
    output logic                    LHBL,
    output logic                    LVBL,
    output logic                    HS,
    output logic                    VS,
    // Colour output
    output logic                    LHBL_dly,
    output logic                    LVBL_dly,
    output gunsmoke_pkg::col_t      red,
    output gunsmoke_pkg::col_t      green,
    output gunsmoke_pkg::col_t      blue,
    // SDRAM load port
    output gunsmoke_pkg::sd_addr_t  prog_addr,
    output logic [7:0]              prog_data,
    output logic [1:0]              prog_mask,
    output logic                    prog_we
);

    gunsmoke_pkg::prom_we_t prom_we;

    gunsmoke_cen u_cen (
        .clk    (clk),
        .reset  (reset),
        .cen12  (cen12),
        .cen6   (cen6),
        .cen3   (cen3),
        .cen1p5 (cen1p5)
    );

    gunsmoke_timer u_timer (
        .clk   (clk),
        .reset (reset),
        .cen6  (cen6),
        .H     (H),
        .V     (V),
        .LHBL  (LHBL),
        .LVBL  (LVBL),
        .HS    (HS),
        .VS    (VS)
    );

    gunsmoke_prom_we u_prom_we (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    // PROMs take the low address and colour bits of the load bus
    gunsmoke_colmix u_colmix (
        .clk       (clk),
        .reset     (reset),
        .cen6      (cen6),
        .pixel     (pixel),
        .LHBL      (LHBL),
        .LVBL      (LVBL),
        .prog_addr (prog_addr[7:0]),
        .prog_din  (prog_data[3:0]),
        .prom_we   (prom_we),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .LHBL_dly  (LHBL_dly),
        .LVBL_dly  (LVBL_dly)
    );

endmodule

/* testbench/gunsmoke_video_tb.sv */
/*
 * Directed testbench for the video core. Runs reset, clock enable, timing,
 * download and palette lookup tests against reference models and reports.
 */

`timescale 1ns/1ps

`include "gunsmoke_defines.svh"

module gunsmoke_video_tb;

    localparam int FRAME_CLKS     = `GS_H_TOTAL * `GS_V_TOTAL * 8;
    // Two frames of run time plus room for loading and reset
    localparam int TIMEOUT_CYCLES = FRAME_CLKS * 2 + 20000;

    logic                    clk;
    logic                    reset;
    gunsmoke_pkg::pix_t      pixel;
    logic                    downloading;
    gunsmoke_pkg::dl_addr_t  ioctl_addr;
    logic [7:0]              ioctl_data;
    logic                    ioctl_wr;
    logic                    cen12;
    logic                    cen6;
    logic                    cen3;
    logic                    cen1p5;
    gunsmoke_pkg::hpos_t     H;
    gunsmoke_pkg::vpos_t     V;
    logic                    LHBL;
    logic                    LVBL;
    logic                    HS;
    logic                    VS;
    logic                    LHBL_dly;
    logic                    LVBL_dly;
    gunsmoke_pkg::col_t      red;
    gunsmoke_pkg::col_t      green;
    gunsmoke_pkg::col_t      blue;
    gunsmoke_pkg::sd_addr_t  prog_addr;
    logic [7:0]              prog_data;
    logic [1:0]              prog_mask;
    logic                    prog_we;

    int seed;
    int error_count;
    int pass_count;
    int fail_count;
    int cycle_count = 0;

    // Palette models, filled as the PROMs are downloaded
    gunsmoke_pkg::col_t red_model [256];
    gunsmoke_pkg::col_t green_model [256];
    gunsmoke_pkg::col_t blue_model [256];

    // Pixels and blanking in flight through the mixer
    gunsmoke_pkg::pix_t hist_pix [$];
    logic               hist_hbl [$];
    logic               hist_vbl [$];

    gunsmoke_video u_gunsmoke_video (
        .clk         (clk),
        .reset       (reset),
        .pixel       (pixel),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .cen12       (cen12),
        .cen6        (cen6),
        .cen3        (cen3),
        .cen1p5      (cen1p5),
        .H           (H),
        .V           (V),
        .LHBL        (LHBL),
        .LVBL        (LVBL),
        .HS          (HS),
        .VS          (VS),
        .LHBL_dly    (LHBL_dly),
        .LVBL_dly    (LVBL_dly),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
        $display("=== FAIL ===");
        $finish;
    end

    // Inputs change 1 ns after the edge, outputs are read there too
    task step_clk;
        @(posedge clk);
        #1;
    endtask

    task check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task check_col(input string name, input gunsmoke_pkg::col_t got,
                   input gunsmoke_pkg::col_t exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task check_pos(input string name, input gunsmoke_pkg::hpos_t got,
                   input gunsmoke_pkg::hpos_t exp);
        if (got !== exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task check_sd(input gunsmoke_pkg::sd_addr_t got_addr, input logic [7:0] got_data,
                  input logic [1:0] got_mask, input gunsmoke_pkg::sd_addr_t exp_addr,
                  input logic [7:0] exp_data, input logic [1:0] exp_mask);
        if (got_addr !== exp_addr) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: prog_addr got %0h expected %0h",
                     $time, got_addr, exp_addr);
        end
        if (got_data !== exp_data) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: prog_data got %0h expected %0h",
                     $time, got_data, exp_data);
        end
        if (got_mask !== exp_mask) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: prog_mask got %b expected %b",
                     $time, got_mask, exp_mask);
        end
    endtask

    task check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            error_count = error_count + 1;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task end_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count = pass_count + 1;
            $display("Test %s: passed", name);
        end else begin
            fail_count = fail_count + 1;
            $display("Test %s: failed with %0d errors", name, error_count - errors_before);
        end
    endtask

    // One accepted byte, returns on the clk where its write shows up
    task download_byte(input gunsmoke_pkg::dl_addr_t addr, input logic [7:0] data);
        downloading = 1'b1;
        ioctl_addr  = addr;
        ioctl_data  = data;
        ioctl_wr    = 1'b1;
        step_clk();
        ioctl_wr    = 1'b0;
    endtask

    task check_cleared_outputs;
        check_bit("cen12", cen12, 1'b0);
        check_bit("cen6", cen6, 1'b0);
        check_bit("cen3", cen3, 1'b0);
        check_bit("cen1p5", cen1p5, 1'b0);
        check_bit("prog_we", prog_we, 1'b0);
        check_col("red", red, 4'd0);
        check_col("green", green, 4'd0);
        check_col("blue", blue, 4'd0);
        check_bit("LHBL_dly", LHBL_dly, 1'b0);
        check_bit("LVBL_dly", LVBL_dly, 1'b0);
        check_pos("H", H, 9'd0);
        check_pos("V", V, 9'd0);
    endtask

    // Random pixel per cen6, outputs compared with the pixel two ticks back
    task run_mixer_ticks(input int n_ticks, input bit check_colour, input bit check_blank);
        int                 done;
        gunsmoke_pkg::pix_t exp_pix;
        logic               exp_hbl;
        logic               exp_vbl;
        logic [31:0]        rnd;
        done = 0;
        hist_pix.delete();
        hist_hbl.delete();
        hist_vbl.delete();
        while (done < n_ticks) begin
            step_clk();
            if (cen6) begin
                if (hist_pix.size() == 2) begin
                    exp_pix = hist_pix.pop_front();
                    exp_hbl = hist_hbl.pop_front();
                    exp_vbl = hist_vbl.pop_front();
                    if (check_blank) begin
                        check_bit("LHBL_dly", LHBL_dly, exp_hbl);
                        check_bit("LVBL_dly", LVBL_dly, exp_vbl);
                    end
                    if (exp_hbl && exp_vbl) begin
                        if (check_colour) begin
                            check_col("red", red, red_model[exp_pix]);
                            check_col("green", green, green_model[exp_pix]);
                            check_col("blue", blue, blue_model[exp_pix]);
                        end
                    end else if (check_blank) begin
                        check_col("red", red, 4'd0);
                        check_col("green", green, 4'd0);
                        check_col("blue", blue, 4'd0);
                    end
                end
                rnd   = $random(seed);
                pixel = rnd[7:0];
                hist_pix.push_back(pixel);
                hist_hbl.push_back(LHBL);
                hist_vbl.push_back(LVBL);
                done = done + 1;
            end
        end
    endtask

    task test_reset_state;
        int errs;
        errs  = error_count;
        reset = 1'b1;
        repeat (5) begin
            step_clk();
            check_cleared_outputs();
        end
        reset = 1'b0;
        step_clk();
        check_cleared_outputs();
        check_bit("LHBL", LHBL, 1'b1);
        check_bit("LVBL", LVBL, 1'b0);
        check_bit("HS", HS, 1'b0);
        check_bit("VS", VS, 1'b0);
        end_test("reset state", errs);
    endtask

    task test_clock_enables;
        int errs;
        int n12;
        int n6;
        int n3;
        int n1p5;
        errs = error_count;
        n12  = 0;
        n6   = 0;
        n3   = 0;
        n1p5 = 0;
        repeat (64) begin
            step_clk();
            if (cen12) n12 = n12 + 1;
            if (cen6) begin
                n6 = n6 + 1;
                check_bit("cen12 with cen6", cen12, 1'b1);
            end
            if (cen3) begin
                n3 = n3 + 1;
                check_bit("cen6 with cen3", cen6, 1'b1);
            end
            if (cen1p5) begin
                n1p5 = n1p5 + 1;
                check_bit("cen3 with cen1p5", cen3, 1'b1);
            end
        end
        check_count("cen12 pulses", n12, 16);
        check_count("cen6 pulses", n6, 8);
        check_count("cen3 pulses", n3, 4);
        check_count("cen1p5 pulses", n1p5, 2);
        end_test("clock enables", errs);
    endtask

    task test_video_timing;
        int   errs;
        int   n;
        int   exp_h;
        int   exp_v;
        logic prev_cen;
        errs = error_count;
        step_clk();
        exp_h    = int'(H);
        exp_v    = int'(V);
        prev_cen = cen6;
        for (n = 0; n < FRAME_CLKS; n++) begin
            step_clk();
            // Counts move on the edge that sampled cen6 high
            if (prev_cen) begin
                exp_h = exp_h + 1;
                if (exp_h == `GS_H_TOTAL) begin
                    exp_h = 0;
                    exp_v = exp_v + 1;
                    if (exp_v == `GS_V_TOTAL) exp_v = 0;
                end
            end
            check_pos("H", H, gunsmoke_pkg::hpos_t'(exp_h));
            check_pos("V", V, gunsmoke_pkg::hpos_t'(exp_v));
            check_bit("LHBL", LHBL, exp_h < `GS_H_ACTIVE);
            check_bit("LVBL", LVBL, exp_v >= `GS_V_START && exp_v < `GS_V_END);
            check_bit("HS", HS, exp_h >= `GS_HS_START && exp_h < `GS_HS_END);
            check_bit("VS", VS, exp_v >= `GS_VS_START && exp_v < `GS_VS_END);
            prev_cen = cen6;
        end
        end_test("video timing", errs);
    endtask

    task test_sdram_download;
        int                     errs;
        int                     i;
        logic [31:0]            rnd;
        gunsmoke_pkg::dl_addr_t addr;
        logic [7:0]             data;
        errs = error_count;
        for (i = 0; i < 16; i++) begin
            rnd  = $random(seed);
            rnd  = rnd % {10'd0, `GS_PROM_ADDR};
            addr = rnd[21:0];
            rnd  = $random(seed);
            data = rnd[7:0];
            download_byte(addr, data);
            check_bit("prog_we", prog_we, 1'b1);
            check_sd(prog_addr, prog_data, prog_mask, {1'b0, addr[21:1]}, data,
                     addr[0] ? 2'b01 : 2'b10);
            step_clk();
            check_bit("prog_we", prog_we, 1'b0);
        end
        // Strobes without downloading are ignored
        downloading = 1'b0;
        ioctl_wr    = 1'b1;
        repeat (4) begin
            rnd        = $random(seed);
            ioctl_addr = rnd[21:0];
            step_clk();
            check_bit("prog_we", prog_we, 1'b0);
        end
        ioctl_wr = 1'b0;
        step_clk();
        check_bit("prog_we", prog_we, 1'b0);
        end_test("SDRAM download", errs);
    endtask

    task test_prom_lookup;
        int          errs;
        int          idx;
        int          sel;
        logic [31:0] rnd;
        logic [31:0] sel_bits;
        logic [31:0] idx_bits;
        errs = error_count;
        for (idx = 0; idx < 256; idx++) begin
            for (sel = 0; sel < `GS_PROM_COUNT; sel++) begin
                rnd      = $random(seed);
                sel_bits = sel;
                idx_bits = idx;
                download_byte(`GS_PROM_ADDR + {10'd0, sel_bits[3:0], idx_bits[7:0]},
                              rnd[7:0]);
                check_bit("prog_we", prog_we, 1'b0);
                if (sel == 0) red_model[idx] = rnd[3:0];
                if (sel == 1) green_model[idx] = rnd[3:0];
                if (sel == 2) blue_model[idx] = rnd[3:0];
                step_clk();
            end
        end
        // Selector 5 is outside the kept PROMs
        rnd = $random(seed);
        download_byte(`GS_PROM_ADDR + {10'd0, 4'd5, rnd[15:8]}, rnd[7:0]);
        check_bit("prog_we", prog_we, 1'b0);
        step_clk();
        downloading = 1'b0;
        step_clk();
        while (!(cen6 && LHBL && LVBL)) begin
            step_clk();
        end
        run_mixer_ticks(3 * `GS_H_TOTAL, 1'b1, 1'b0);
        end_test("PROM load and lookup", errs);
    endtask

    task test_blanking_delay;
        int errs;
        errs = error_count;
        // Start on the last active line so LVBL falls during the run
        while (!(cen6 && V == gunsmoke_pkg::vpos_t'(`GS_V_END - 1))) begin
            step_clk();
        end
        run_mixer_ticks(2 * `GS_H_TOTAL, 1'b0, 1'b1);
        end_test("blanking delay", errs);
    endtask

    initial begin
        seed        = 32'h59e7_5364;
        error_count = 0;
        pass_count  = 0;
        fail_count  = 0;
        reset       = 1'b1;
        pixel       = '0;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = 8'd0;
        ioctl_wr    = 1'b0;

        test_reset_state();
        test_clock_enables();
        test_video_timing();
        test_sdram_download();
        test_prom_lookup();
        test_blanking_delay();

        $display("Tests passed: %0d  failed: %0d  check errors: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
